//--- vic_chip_pkg.sv
`default_nettype none

package vic_chip_pkg;

    // chip model codes, order matches the strap pins
    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6569     = 2'd1,
        CHIP6567R56A = 2'd2,
        CHIP6569R1   = 2'd3
    } chip_t;

    // cpu cycles per raster line, indexed by chip code
    localparam logic [6:0] CYCLES_NTSC_R8  = 7'd65;
    localparam logic [6:0] CYCLES_PAL      = 7'd63;
    localparam logic [6:0] CYCLES_NTSC_R56 = 7'd64;

    // raster lines per frame
    localparam logic [8:0] LINES_NTSC_R8  = 9'd263;
    localparam logic [8:0] LINES_PAL      = 9'd312;
    localparam logic [8:0] LINES_NTSC_R56 = 9'd262;

    function automatic logic [6:0] cycles_per_line(input chip_t model);
        case (model)
            CHIP6567R8:   return CYCLES_NTSC_R8;
            CHIP6567R56A: return CYCLES_NTSC_R56;
            // both pal parts share the 63 cycle line
            default:      return CYCLES_PAL;
        endcase
    endfunction

    function automatic logic [8:0] lines_per_frame(input chip_t model);
        case (model)
            CHIP6567R8:   return LINES_NTSC_R8;
            CHIP6567R56A: return LINES_NTSC_R56;
            default:      return LINES_PAL;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- vic_timing_pkg.sv
`default_nettype none

package vic_timing_pkg;

    // phase counter width, one cpu cycle is 2**PHASE_W clk_dot4x cycles
    localparam int PHASE_W = 5;

    // width of cycle_num, covers the 65 cycle ntsc line
    localparam int CYCLE_W = 7;

    // width of raster_line, covers 312 pal lines
    localparam int LINE_W = 9;

    // reset hold in clk_dot4x cycles
    // short value for simulation, a board build wants roughly 4 million
    localparam int RST_HOLD_CYCLES = 64;

endpackage

`default_nettype wire

//--- reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reset_gen
    import vic_chip_pkg::*, vic_timing_pkg::*;
#(
    parameter int HOLD_CYCLES = RST_HOLD_CYCLES
) (
    input  wire        clk_dot4x,
    input  wire        internal_rst,
    input  wire        locked,
    input  wire chip_t chip_strap,
    output logic       rst,
    output chip_t      chip
);

    // counter must be able to hold HOLD_CYCLES itself
    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_CYCLES - 1);

    logic              locked_meta;
    logic              locked_sync;
    logic [HOLD_W-1:0] hold_cnt;

    // two flop synchronizer, locked comes straight from the pll
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst) begin
            locked_meta <= 1'b0;
            locked_sync <= 1'b0;
        end else begin
            locked_meta <= locked;
            locked_sync <= locked_meta;
        end
    end

    // hold counter, cleared on power-on hold or any loss of lock
    // rst drops on the edge where the count reaches HOLD_CYCLES
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst || !locked_sync) begin
            hold_cnt <= '0;
            rst      <= 1'b1;
        end else if (rst) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == HOLD_LAST) begin
                rst <= 1'b0;
            end
        end
    end

    // chip model is sampled once, on the release edge
    // a lock loss keeps the old model until the next release
    always_ff @(posedge clk_dot4x) begin
        if (internal_rst) begin
            chip <= CHIP6567R8;
        end else if (locked_sync && rst && hold_cnt == HOLD_LAST) begin
            chip <= chip_strap;
        end
    end

    // strap changes after release must never reach the timing logic
    a_chip_stable : assert property (
        @(posedge clk_dot4x) disable iff (internal_rst)
        (!rst && !$past(rst)) |-> $stable(chip)
    ) else $error("chip changed while out of reset");

endmodule

`default_nettype wire

//--- dot_phase.sv
`timescale 1ns/1ps
`default_nettype none

module dot_phase
    import vic_timing_pkg::*;
(
    input  wire  clk_dot4x,
    input  wire  rst,
    output logic dot_ce,
    output logic phi,
    output logic cycle_end
);

    logic [PHASE_W-1:0] phase;

    // free running phase within one cpu cycle
    // wraps 31 to 0
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // decodes are registered, so each output trails its count by one clock
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_ce    <= 1'b0;
            phi       <= 1'b0;
            cycle_end <= 1'b0;
        end else begin
            // one dot per four clk_dot4x cycles on counts 3, 7 .. 31
            dot_ce    <= &phase[1:0];
            // phi low for the first half of the cycle and high for the second
            phi       <= phase[PHASE_W-1];
            // last count of the cpu cycle
            cycle_end <= &phase;
        end
    end

    // end of cycle must land on a dot and inside phi high
    a_cycle_end_aligned : assert property (
        @(posedge clk_dot4x) disable iff (rst)
        cycle_end |-> (dot_ce && phi)
    ) else $error("cycle_end outside dot_ce and phi");

endmodule

`default_nettype wire

//--- raster_counter.sv
`timescale 1ns/1ps
`default_nettype none

module raster_counter
    import vic_chip_pkg::*, vic_timing_pkg::*;
(
    input  wire                clk_dot4x,
    input  wire                rst,
    input  wire                cycle_end,
    input  wire chip_t         chip,
    output logic [CYCLE_W-1:0] cycle_num,
    output logic [LINE_W-1:0]  raster_line,
    output logic               frame_start
);

    logic [CYCLE_W-1:0] last_cycle;
    logic [LINE_W-1:0]  last_line;
    logic               line_wrap;
    logic               frame_wrap;

    // wrap points for the selected model
    // chip only moves at reset release, so these are quasi static
    assign last_cycle = cycles_per_line(chip) - 1'b1;
    assign last_line  = lines_per_frame(chip) - 1'b1;

    // end of line and end of frame
    // both qualified by the cycle strobe
    assign line_wrap  = cycle_end && (cycle_num == last_cycle);
    assign frame_wrap = line_wrap && (raster_line == last_line);

    // cpu cycle within the line
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle_num <= '0;
        end else if (line_wrap) begin
            cycle_num <= '0;
        end else if (cycle_end) begin
            cycle_num <= cycle_num + 1'b1;
        end
    end

    // raster line within the frame
    // steps when the cycle count wraps
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line <= '0;
        end else if (frame_wrap) begin
            raster_line <= '0;
        end else if (line_wrap) begin
            raster_line <= raster_line + 1'b1;
        end
    end

    // one clock pulse on the first clock of line 0, cycle 0
    // only set by a real wrap, so no pulse right after reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= frame_wrap;
        end
    end

    // counters never leave the range of the selected model
    a_cycle_range : assert property (
        @(posedge clk_dot4x) disable iff (rst)
        cycle_num < cycles_per_line(chip)
    ) else $error("cycle_num out of range for chip");

    a_line_range : assert property (
        @(posedge clk_dot4x) disable iff (rst)
        raster_line < lines_per_frame(chip)
    ) else $error("raster_line out of range for chip");

endmodule

`default_nettype wire

//--- vic_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_timing_top
    import vic_chip_pkg::*, vic_timing_pkg::*;
(
    input  wire                clk_dot4x,
    input  wire                internal_rst,
    input  wire                locked,
    input  wire chip_t         chip_strap,
    output logic               rst,
    output chip_t              chip,
    output logic               dot_ce,
    output logic               phi,
    output logic [CYCLE_W-1:0] cycle_num,
    output logic [LINE_W-1:0]  raster_line,
    output logic               frame_start
);

    // end of cpu cycle, dot_phase to raster_counter
    logic cycle_end;

    // lock sync, reset hold and chip model latch
    reset_gen u_reset_gen (
        .clk_dot4x    (clk_dot4x),
        .internal_rst (internal_rst),
        .locked       (locked),
        .chip_strap   (chip_strap),
        .rst          (rst),
        .chip         (chip)
    );

    // dot enable and cpu phase from the 4x clock
    dot_phase u_dot_phase (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .dot_ce    (dot_ce),
        .phi       (phi),
        .cycle_end (cycle_end)
    );

    // cycle and raster line position
    raster_counter u_raster_counter (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .cycle_end   (cycle_end),
        .chip        (chip),
        .cycle_num   (cycle_num),
        .raster_line (raster_line),
        .frame_start (frame_start)
    );

endmodule

`default_nettype wire

//--- tb_vic_timing_table.svh
`ifndef TB_VIC_TIMING_TABLE_SVH
`define TB_VIC_TIMING_TABLE_SVH

// one row per run through reset, release and a full frame
// strap is driven on chip_strap before locked rises
// cycles and lines are the expected line and frame lengths
typedef struct packed {
    chip_t      strap;
    logic [6:0] cycles;
    logic [8:0] lines;
} table_row_t;

localparam int ROW_COUNT = 5;

// 6569 comes twice, its second run also carries the lock loss
localparam table_row_t ROW_TABLE [ROW_COUNT] = '{
    '{strap: CHIP6567R8,   cycles: 7'd65, lines: 9'd263},
    '{strap: CHIP6569,     cycles: 7'd63, lines: 9'd312},
    '{strap: CHIP6567R56A, cycles: 7'd64, lines: 9'd262},
    '{strap: CHIP6569R1,   cycles: 7'd63, lines: 9'd312},
    '{strap: CHIP6569,     cycles: 7'd63, lines: 9'd312}
};

`endif

//--- tb_vic_timing.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vic_timing
    import vic_chip_pkg::*, vic_timing_pkg::*;
();

    `include "tb_vic_timing_table.svh"

    localparam int CLK_PERIOD  = 20;
    localparam int ROW_MARGIN  = 200;
    // locked crosses two flops before the hold counter sees it
    localparam int SYNC_STAGES = 2;
    localparam int RELEASE_EDGES = RST_HOLD_CYCLES + SYNC_STAGES;
    // two synchronizer edges, then the edge that sets rst
    localparam int LOSS_EDGES = SYNC_STAGES + 1;

    logic               clk_dot4x;
    logic               internal_rst;
    logic               locked;
    chip_t              chip_strap;
    logic               rst;
    chip_t              chip;
    logic               dot_ce;
    logic               phi;
    logic [CYCLE_W-1:0] cycle_num;
    logic [LINE_W-1:0]  raster_line;
    logic               frame_start;
    logic [31:0]        rng_state;

    vic_timing_top u_dut (
        .clk_dot4x    (clk_dot4x),
        .internal_rst (internal_rst),
        .locked       (locked),
        .chip_strap   (chip_strap),
        .rst          (rst),
        .chip         (chip),
        .dot_ce       (dot_ce),
        .phi          (phi),
        .cycle_num    (cycle_num),
        .raster_line  (raster_line),
        .frame_start  (frame_start)
    );

    initial clk_dot4x = 1'b0;
    always #10 clk_dot4x = ~clk_dot4x;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one frame plus margin per row
    // the last row adds the lock loss tail
    function automatic longint test_clocks();
        longint total;
        longint line_clk;
        int     i;
        total = 0;
        for (i = 0; i < ROW_COUNT; i++) begin
            line_clk = longint'(ROW_TABLE[i].cycles) * 32;
            total += line_clk * longint'(ROW_TABLE[i].lines) + ROW_MARGIN;
        end
        line_clk = longint'(ROW_TABLE[ROW_COUNT-1].cycles) * 32;
        total += line_clk * longint'(ROW_TABLE[ROW_COUNT-1].lines) / 2;
        total += 2 * line_clk + ROW_MARGIN;
        return total;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping simulation");
    endtask

    task automatic check_chip(input chip_t actual, input chip_t expected);
        if (actual !== expected) begin
            $display("** Error chip: got 0x%h, expected 0x%h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [8:0] actual,
                               input logic [8:0] expected);
        if (actual !== expected) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    // drive and sample 1 ns after the rising edge
    // all flops have settled by then
    task automatic step();
        @(posedge clk_dot4x);
        #1;
    endtask

    task automatic check_reset_state(input chip_t exp_chip);
        check_bit("rst", rst, 1'b1);
        check_chip(chip, exp_chip);
        check_bit("dot_ce", dot_ce, 1'b0);
        check_bit("phi", phi, 1'b0);
        check_count("cycle_num", {2'b00, cycle_num}, 9'd0);
        check_count("raster_line", raster_line, 9'd0);
        check_bit("frame_start", frame_start, 1'b0);
    endtask

    // raise locked after a random 2 to 9 clocks and time the release
    task automatic lock_and_release(input chip_t strap);
        int delay;
        int edges;
        rng_state = xorshift32(rng_state);
        delay = 2 + int'(rng_state[2:0]);
        chip_strap = strap;
        repeat (delay) step();
        locked = 1'b1;
        edges = 0;
        while (rst === 1'b1 && edges <= RELEASE_EDGES) begin
            step();
            edges++;
        end
        if (rst !== 1'b0) begin
            $display("rst did not fall within %0d edges after locked rose", edges);
            abort_run();
        end
        check_count("rst release edges", 9'(edges), 9'(RELEASE_EDGES));
        check_chip(chip, strap);
    endtask

    // t counts clocks since the release sample
    // phase count equals t
    // every output trails its count by one clock
    task automatic run_checked(input chip_t exp_chip, input int cpl, input int lpf,
                               input int clocks, input bit scramble);
        int   t;
        int   n;
        logic exp_fs;
        for (t = 1; t <= clocks; t++) begin
            step();
            // completed cpu cycles so far
            n = (t - 1) / 32;
            exp_fs = ((t - 1) % 32 == 0) && (n > 0) && (n % (cpl * lpf) == 0);
            check_bit("rst", rst, 1'b0);
            check_chip(chip, exp_chip);
            check_bit("dot_ce", dot_ce, t % 4 == 0);
            check_bit("phi", phi, (t - 1) % 32 >= 16);
            check_count("cycle_num", {2'b00, cycle_num}, 9'(n % cpl));
            check_count("raster_line", raster_line, 9'((n / cpl) % lpf));
            check_bit("frame_start", frame_start, exp_fs);
            // strap noise after release must not reach chip
            if (scramble && t % 32 == 5) begin
                rng_state = xorshift32(rng_state);
                chip_strap = chip_t'(rng_state[1:0]);
            end
        end
    endtask

    initial begin
        longint limit;
        limit = test_clocks() * CLK_PERIOD;
        #(limit);
        $display("simulation timed out");
        abort_run();
    end

    initial begin
        int    row;
        int    cpl;
        int    lpf;
        int    frame_clk;
        int    edges;
        chip_t strap;
        rng_state = 32'd4239;
        internal_rst = 1'b1;
        locked = 1'b0;
        chip_strap = CHIP6567R8;
        for (row = 0; row < ROW_COUNT; row++) begin
            strap = ROW_TABLE[row].strap;
            cpl = int'(ROW_TABLE[row].cycles);
            lpf = int'(ROW_TABLE[row].lines);
            frame_clk = cpl * lpf * 32;
            internal_rst = 1'b1;
            locked = 1'b0;
            chip_strap = strap;
            repeat (5) step();
            check_reset_state(CHIP6567R8);
            internal_rst = 1'b0;
            lock_and_release(strap);
            if (row == ROW_COUNT - 1) begin
                // last row runs on into the next frame before lock is lost
                run_checked(strap, cpl, lpf, frame_clk + frame_clk / 2, 1'b1);
                locked = 1'b0;
                edges = 0;
                while (rst === 1'b0 && edges <= LOSS_EDGES) begin
                    step();
                    edges++;
                end
                if (rst !== 1'b1) begin
                    $display("rst did not rise within %0d edges after locked dropped", edges);
                    abort_run();
                end
                check_count("rst loss edges", 9'(edges), 9'(LOSS_EDGES));
                // counters clear one clock behind rst
                // chip keeps the old model
                step();
                check_reset_state(strap);
                lock_and_release(strap);
                run_checked(strap, cpl, lpf, 2 * cpl * 32 + 40, 1'b0);
            end else begin
                run_checked(strap, cpl, lpf, frame_clk + 40, 1'b1);
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
vic_chip_pkg.sv
vic_timing_pkg.sv
reset_gen.sv
dot_phase.sv
raster_counter.sv
vic_timing_top.sv
tb_vic_timing.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --assert --timescale 1ns/1ps -f compile.f \
    --top-module tb_vic_timing -o tb_vic_timing &&
{ ./obj_dir/tb_vic_timing > sim.log 2>&1 || true; } &&
grep -q "^Test passed$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
